// File: design/tiny16_core.sv
`default_nettype none

module tiny16_core (
    input  logic                     clk,
    input  logic                     reset,
    input  tiny16_sys_pkg::word_t    data_in,
    input  logic                     ready,
    output tiny16_sys_pkg::word_t    address,
    output tiny16_sys_pkg::word_t    data_out,
    output logic                     rd,
    output logic                     wr,
    output logic                     hlt,
    output logic                     error,
    output tiny16_isa_pkg::instr_t   instr,
    output logic                     c,
    output logic                     z,
    output logic                     n,
    input  logic                     halt,
    input  logic                     nop,
    input  logic                     br,
    input  logic                     mvi,
    input  logic                     load,
    input  logic                     store,
    input  logic                     movrr,
    input  logic                     adi,
    input  logic                     err,
    input  logic                     hi,
    input  logic                     branch_taken,
    input  tiny16_isa_pkg::reg_idx_t src_sel,
    input  tiny16_isa_pkg::reg_idx_t dst_sel,
    input  logic [7:0]               imm_byte,
    input  tiny16_sys_pkg::word_t    offset8_ext,
    input  tiny16_sys_pkg::word_t    offset10_ext
);
    import tiny16_isa_pkg::*;
    import tiny16_sys_pkg::*;

    stage_t        stage;
    logic          advance;
    logic          bus_done;
    logic          stop;
    logic          mem_op;
    logic          rd_next;
    logic          wr_next;
    word_t         regs [4];
    word_t         result;
    word_t         base;
    word_t         pc_next;
    logic [WORD_W:0] sum;
    logic          wb_en;
    word_t         wb_word;
    word_t         pc_after_wb;

    assign bus_done = (rd || wr) && ready;
    assign stop     = hlt || halt || err;
    assign mem_op   = load || store;

    // fetch and memory wait on the bus, exec waits on nothing
    always_comb begin
        advance = 1'b0;
        rd_next = 1'b0;
        wr_next = 1'b0;
        case (stage)
            ST_FETCH: begin
                advance = bus_done;
                rd_next = !bus_done;
            end
            ST_EXEC: begin
                advance = !stop;
                rd_next = !stop && load;
                wr_next = !stop && store;
            end
            ST_MEM: begin
                advance = bus_done || !mem_op;
                rd_next = rd && !bus_done;
                wr_next = wr && !bus_done;
            end
            ST_WB: begin
                advance = 1'b1;
                rd_next = 1'b1;
            end
            default: advance = 1'b1;
        endcase
    end

    assign base    = load ? regs[src_sel] : regs[dst_sel];
    assign sum     = {1'b0, regs[src_sel]} + {1'b0, offset10_ext};
    assign pc_next = regs[REG_PC] + ((br && branch_taken) ? offset10_ext : word_t'(1));

    // write-back word, mvi merges one byte into the old value
    assign wb_en = load || movrr || adi || mvi;
    always_comb begin
        wb_word = result;
        if (mvi) begin
            if (hi)
                wb_word = {imm_byte, regs[dst_sel][7:0]};
            else
                wb_word = {regs[dst_sel][15:8], imm_byte};
        end
    end

    // next fetch address, honours a write to PC
    assign pc_after_wb = (wb_en && dst_sel == REG_PC) ? wb_word : regs[REG_PC];

    always_ff @(posedge clk) begin
        if (!reset) begin
            stage        <= ST_FETCH;
            rd           <= 1'b0;
            wr           <= 1'b0;
            hlt          <= 1'b0;
            error        <= 1'b0;
            c            <= 1'b0;
            z            <= 1'b0;
            n            <= 1'b0;
            address      <= '0;
            regs[REG_PC] <= '0;
        end else begin
            rd <= rd_next;
            wr <= wr_next;
            if (advance)
                stage <= {stage[STAGE_W-2:0], stage[STAGE_W-1]};
            if (stage == ST_EXEC && !hlt) begin
                if (halt || err) begin
                    hlt   <= 1'b1;
                    error <= err;
                end else begin
                    regs[REG_PC] <= pc_next;
                    if (!nop) begin
                        if (mem_op)
                            address <= base + offset8_ext;
                        if (adi) begin
                            c <= sum[WORD_W];
                            z <= (sum[WORD_W-1:0] == '0);
                            n <= sum[WORD_W-1];
                        end
                    end
                end
            end
            if (stage == ST_WB) begin
                if (wb_en)
                    regs[dst_sel] <= wb_word;
                address <= pc_after_wb;
            end
        end
    end

    // instruction, store data and result latch
    always_ff @(posedge clk) begin
        if (stage == ST_FETCH && bus_done)
            instr <= data_in;
        if (stage == ST_EXEC && !stop && !nop) begin
            if (store)
                data_out <= regs[src_sel];
            if (adi)
                result <= sum[WORD_W-1:0];
            else if (movrr)
                result <= regs[src_sel];
        end
        if (stage == ST_MEM && load && bus_done)
            result <= data_in;
    end

endmodule

`default_nettype wire

// File: design/tiny16_decoder.sv
`default_nettype none

module tiny16_decoder (
    input  tiny16_isa_pkg::instr_t   instr,
    input  logic                     c,
    input  logic                     z,
    input  logic                     n,
    output logic                     halt,
    output logic                     nop,
    output logic                     br,
    output logic                     mvi,
    output logic                     load,
    output logic                     store,
    output logic                     movrr,
    output logic                     adi,
    output logic                     err,
    output logic                     hi,
    output logic                     branch_taken,
    output tiny16_isa_pkg::reg_idx_t src_sel,
    output tiny16_isa_pkg::reg_idx_t dst_sel,
    output logic [7:0]               imm_byte,
    output tiny16_sys_pkg::word_t    offset8_ext,
    output tiny16_sys_pkg::word_t    offset10_ext
);
    import tiny16_isa_pkg::*;
    import tiny16_sys_pkg::*;

    opcode_t    opcode;
    logic       sys_op;
    logic [2:0] cond_hits;

    // both views agree on the opcode nibble
    assign opcode = instr.mem_f.opcode;
    assign sys_op = (opcode == OP_SYS);

    assign halt  = sys_op && (instr == WORD_HALT);
    assign nop   = sys_op && (instr == WORD_NOP);
    assign br    = (opcode == OP_BR) || opcode[3];
    assign mvi   = (opcode == OP_MVI) && !instr.imm_f.spare;
    assign load  = (opcode == OP_LOAD);
    assign store = (opcode == OP_STORE);
    assign movrr = (opcode == OP_MOV);
    assign adi   = (opcode == OP_ADI);

    // anything outside the defined set
    assign err = !(halt || nop || br || mvi || load || store || movrr || adi);

    assign hi       = instr.imm_f.hi;
    assign imm_byte = instr.imm_f.data;

    // load/store displacement
    assign offset8_ext = {{(WORD_W - OFFSET_W){instr.mem_f.offset[OFFSET_W-1]}},
                          instr.mem_f.offset};

    // branch displacement and add immediate
    assign offset10_ext = {{(WORD_W - OFFSET10_W){instr.mem_f.dst[REG_IDX_W-1]}},
                           instr.mem_f.dst, instr.mem_f.offset};

    // store: src is the data, dst the base
    // load: src is the base, dst the target
    always_comb begin
        src_sel = instr.mem_f.src;
        dst_sel = instr.mem_f.dst;
        if (mvi) begin
            dst_sel = instr.imm_f.rsel;
        end else if (adi) begin
            // adi adds in place
            dst_sel = instr.mem_f.src;
        end
    end

    // any selected flag set, then optional inversion
    assign cond_hits    = opcode[2:0] & {c, z, n};
    assign branch_taken = (|cond_hits) ^ opcode[3];

endmodule

`default_nettype wire

// File: design/tiny16_isa_pkg.sv
`default_nettype none

package tiny16_isa_pkg;

    // instruction word and field widths
    localparam int INSTR_W    = 16;
    localparam int OFFSET_W   = 8;
    localparam int OFFSET10_W = 10;
    localparam int OPCODE_W   = 4;
    localparam int REG_IDX_W  = 2;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam reg_idx_t REG_A  = 2'd0;
    localparam reg_idx_t REG_W  = 2'd1;
    localparam reg_idx_t REG_X  = 2'd2;
    localparam reg_idx_t REG_PC = 2'd3;

    typedef logic [OPCODE_W-1:0] opcode_t;

    // major opcodes, bits 7:4 of the word
    localparam opcode_t OP_SYS   = 4'h0;
    localparam opcode_t OP_BR    = 4'h1;
    localparam opcode_t OP_MVI   = 4'h3;
    localparam opcode_t OP_LOAD  = 4'h4;
    localparam opcode_t OP_STORE = 4'h5;
    localparam opcode_t OP_MOV   = 4'h6;
    localparam opcode_t OP_ADI   = 4'h7;

    // branch group is OP_BR plus every nibble with bit 3 set
    // low three bits mask {c, z, n}, bit 3 inverts the test
    // so 4'h8 is an unconditional branch

    // only two whole words are legal under OP_SYS
    localparam logic [INSTR_W-1:0] WORD_HALT = 16'h0000;
    localparam logic [INSTR_W-1:0] WORD_NOP  = 16'h0001;

    // load, store, mov, adi, branch
    // branch offset is {dst, offset}, adi immediate likewise
    typedef struct packed {
        logic [OFFSET_W-1:0] offset;
        opcode_t             opcode;
        reg_idx_t            dst;
        reg_idx_t            src;
    } mem_fields_t;

    // mvi, spare must be zero
    typedef struct packed {
        logic [OFFSET_W-1:0] data;
        opcode_t             opcode;
        logic                hi;
        logic                spare;
        reg_idx_t            rsel;
    } imm_fields_t;

    typedef union packed {
        mem_fields_t mem_f;
        imm_fields_t imm_f;
    } instr_t;

endpackage

`default_nettype wire

// File: design/tiny16_memory.sv
`default_nettype none

module tiny16_memory #(
    parameter int ADDR_BITS   = 8,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  tiny16_sys_pkg::word_t address,
    input  logic                  rd,
    input  logic                  wr,
    input  tiny16_sys_pkg::word_t data_out,
    output tiny16_sys_pkg::word_t data_in,
    output logic                  ready,
    input  logic                  prog_we,
    input  logic [ADDR_BITS-1:0]  prog_addr,
    input  tiny16_sys_pkg::word_t prog_data
);
    import tiny16_sys_pkg::*;

    localparam int DEPTH = 2 ** ADDR_BITS;
    localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

    word_t                mem [DEPTH];
    logic [CNT_W-1:0]     wait_cnt;
    logic [ADDR_BITS-1:0] index;
    logic                 access;

    assign index  = address[ADDR_BITS-1:0];
    assign access = rd || wr;

    // high when idle, or once the wait count is used up
    assign ready = !access || (wait_cnt == CNT_W'(WAIT_CYCLES));

    // async read, valid in the ready cycle
    assign data_in = mem[index];

    always_ff @(posedge clk) begin
        if (!reset)
            wait_cnt <= '0;
        else if (access && !ready)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    // program load only while the core is held
    always_ff @(posedge clk) begin
        if (!reset) begin
            if (prog_we)
                mem[prog_addr] <= prog_data;
        end else if (wr && ready) begin
            mem[index] <= data_out;
        end
    end

endmodule

`default_nettype wire

// File: design/tiny16_sys_pkg.sv
`default_nettype none

package tiny16_sys_pkg;

    // data word and bus width
    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;

    // one-hot sequencer stages
    localparam int STAGE_W = 4;

    typedef logic [STAGE_W-1:0] stage_t;

    localparam stage_t ST_FETCH = 4'b0001;
    localparam stage_t ST_EXEC  = 4'b0010;
    localparam stage_t ST_MEM   = 4'b0100;
    localparam stage_t ST_WB    = 4'b1000;

endpackage

`default_nettype wire

// File: design/tiny16_system.sv
`default_nettype none

module tiny16_system #(
    parameter int ADDR_BITS   = 8,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  prog_we,
    input  logic [ADDR_BITS-1:0]  prog_addr,
    input  tiny16_sys_pkg::word_t prog_data,
    output logic                  hlt,
    output logic                  error,
    output tiny16_sys_pkg::word_t bus_address,
    output tiny16_sys_pkg::word_t bus_wdata,
    output logic                  bus_wr
);
    import tiny16_isa_pkg::*;
    import tiny16_sys_pkg::*;

    // memory side
    word_t    data_in;
    logic     ready;
    logic     rd;

    // decoder side
    instr_t   instr;
    logic     c;
    logic     z;
    logic     n;
    logic     halt;
    logic     nop;
    logic     br;
    logic     mvi;
    logic     load;
    logic     store;
    logic     movrr;
    logic     adi;
    logic     err;
    logic     hi;
    logic     branch_taken;
    reg_idx_t src_sel;
    reg_idx_t dst_sel;
    logic [7:0] imm_byte;
    word_t    offset8_ext;
    word_t    offset10_ext;

    tiny16_core u_core (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .ready        (ready),
        .address      (bus_address),
        .data_out     (bus_wdata),
        .rd           (rd),
        .wr           (bus_wr),
        .hlt          (hlt),
        .error        (error),
        .instr        (instr),
        .c            (c),
        .z            (z),
        .n            (n),
        .halt         (halt),
        .nop          (nop),
        .br           (br),
        .mvi          (mvi),
        .load         (load),
        .store        (store),
        .movrr        (movrr),
        .adi          (adi),
        .err          (err),
        .hi           (hi),
        .branch_taken (branch_taken),
        .src_sel      (src_sel),
        .dst_sel      (dst_sel),
        .imm_byte     (imm_byte),
        .offset8_ext  (offset8_ext),
        .offset10_ext (offset10_ext)
    );

    tiny16_decoder u_decoder (
        .instr        (instr),
        .c            (c),
        .z            (z),
        .n            (n),
        .halt         (halt),
        .nop          (nop),
        .br           (br),
        .mvi          (mvi),
        .load         (load),
        .store        (store),
        .movrr        (movrr),
        .adi          (adi),
        .err          (err),
        .hi           (hi),
        .branch_taken (branch_taken),
        .src_sel      (src_sel),
        .dst_sel      (dst_sel),
        .imm_byte     (imm_byte),
        .offset8_ext  (offset8_ext),
        .offset10_ext (offset10_ext)
    );

    tiny16_memory #(
        .ADDR_BITS   (ADDR_BITS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_memory (
        .clk       (clk),
        .reset     (reset),
        .address   (bus_address),
        .rd        (rd),
        .wr        (bus_wr),
        .data_out  (bus_wdata),
        .data_in   (data_in),
        .ready     (ready),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

`default_nettype wire

// File: dv/tiny16_system_assert.sv
`default_nettype none

module tiny16_system_assert #(
    parameter int WAIT_CYCLES = 1
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   hlt,
    input logic                   error,
    input logic                   rd,
    input logic                   ready,
    input logic                   bus_wr,
    input tiny16_sys_pkg::word_t  bus_address,
    input tiny16_sys_pkg::word_t  bus_wdata,
    input tiny16_sys_pkg::stage_t stage
);
    timeunit 1ns;
    timeprecision 100ps;

    import tiny16_sys_pkg::*;

    int fail_count = 0;

    // reset values, also in the first cycle after release
    reset_values: assert property (@(posedge clk)
        !reset |=> !hlt && !error && !bus_wr && !rd && stage == ST_FETCH)
        else begin
            fail_count++;
            $error("hlt, error, strobes or stage not cleared by reset");
        end

    // once halted nothing moves until reset
    halt_freezes: assert property (@(posedge clk) disable iff (!reset)
        hlt |-> !rd && !bus_wr ##1 hlt && $stable(stage))
        else begin
            fail_count++;
            $error("bus strobe or stage change after halt");
        end

    // wait states on every access
    ready_delay: assert property (@(posedge clk) disable iff (!reset)
        $rose(rd || bus_wr) |-> ##WAIT_CYCLES ready)
        else begin
            fail_count++;
            $error("ready did not return after the wait states");
        end

    ready_low_first: assert property (@(posedge clk) disable iff (!reset)
        $rose(rd || bus_wr) && (WAIT_CYCLES > 0) |-> !ready)
        else begin
            fail_count++;
            $error("ready high in the first cycle of a waited access");
        end

    // back-pressure keeps the bus still
    bus_held: assert property (@(posedge clk) disable iff (!reset)
        (rd || bus_wr) && !ready |=> $stable({rd, bus_wr, bus_address, bus_wdata}))
        else begin
            fail_count++;
            $error("bus changed while ready was low");
        end

endmodule

bind tiny16_system tiny16_system_assert #(
    .WAIT_CYCLES (WAIT_CYCLES)
) u_assert (
    .clk         (clk),
    .reset       (reset),
    .hlt         (hlt),
    .error       (error),
    .rd          (rd),
    .ready       (ready),
    .bus_wr      (bus_wr),
    .bus_address (bus_address),
    .bus_wdata   (bus_wdata),
    .stage       (u_core.stage)
);

`default_nettype wire

// File: dv/tiny16_system_tb.sv
`default_nettype none

module tiny16_system_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import tiny16_isa_pkg::*;
    import tiny16_sys_pkg::*;

    localparam int ADDR_BITS    = 8;
    localparam int WAIT_CYCLES  = 1;
    localparam int CLK_PERIOD   = 40;
    localparam int NUM_PROGS    = 4;
    localparam int MAX_PROG_LEN = 40;
    // per program: execution, loading, reset and some slack
    localparam int WATCHDOG_CYCLES =
        NUM_PROGS * (MAX_PROG_LEN * (4 + 2 * WAIT_CYCLES) + MAX_PROG_LEN + 4 + 40);

    localparam logic [7:0] MARK_TAKEN     = 8'ha0;
    localparam logic [7:0] MARK_NOT_TAKEN = 8'h50;

    logic                 clk;
    logic                 reset;
    logic                 prog_we;
    logic [ADDR_BITS-1:0] prog_addr;
    word_t                prog_data;
    logic                 hlt;
    logic                 error;
    word_t                bus_address;
    word_t                bus_wdata;
    logic                 bus_wr;

    integer      seed = 79782;
    string       test_name = "none";
    word_t       prog[$];
    logic [31:0] exp_q[$];
    logic [31:0] exp_word;
    logic        wr_seen = 1'b0;
    int          store_errors = 0;
    int          check_errors = 0;
    int          timeouts = 0;

    tiny16_system #(
        .ADDR_BITS   (ADDR_BITS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) tiny16_system_inst (
        .clk         (clk),
        .reset       (reset),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .hlt         (hlt),
        .error       (error),
        .bus_address (bus_address),
        .bus_wdata   (bus_wdata),
        .bus_wr      (bus_wr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction encoders
    function automatic word_t mvi_word(input reg_idx_t r, input logic hi, input logic [7:0] d);
        return {d, OP_MVI, hi, 1'b0, r};
    endfunction

    function automatic word_t mem_word(input opcode_t op, input reg_idx_t dst,
                                       input reg_idx_t src, input logic [7:0] off);
        return {off, op, dst, src};
    endfunction

    function automatic word_t branch_word(input logic [3:0] cond, input logic [9:0] off);
        return {off[7:0], cond, off[9:8], 2'b00};
    endfunction

    function automatic word_t adi_word(input reg_idx_t r, input logic [9:0] imm);
        return {imm[7:0], OP_ADI, imm[9:8], r};
    endfunction

    function automatic word_t sign_extend10(input logic [9:0] imm);
        return {{6{imm[9]}}, imm};
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_q.push_back({addr, data});
    endtask

    task automatic build_move_store();
        logic [7:0] hb;
        logic [7:0] lb;
        logic [7:0] base_lo;
        logic [7:0] off;
        hb      = rand_byte();
        lb      = rand_byte();
        base_lo = 8'h80 | (rand_byte() & 8'h3f);
        off     = rand_byte() & 8'h3f;
        emit(mvi_word(REG_X, 1'b1, 8'h00));
        emit(mvi_word(REG_X, 1'b0, base_lo));
        emit(mvi_word(REG_W, 1'b1, hb));
        emit(mvi_word(REG_W, 1'b0, lb));
        emit(mem_word(OP_MOV, REG_A, REG_W, 8'h00));
        emit(mem_word(OP_STORE, REG_X, REG_A, off));
        emit(WORD_HALT);
        expect_store({8'h00, base_lo} + {8'h00, off}, {hb, lb});
    endtask

    // marker in W is overwritten only on the fall-through path
    task automatic add_case(input int idx, input word_t x, input logic [9:0] imm,
                            input logic [3:0] cond);
        logic [16:0] sum;
        logic        c;
        logic        z;
        logic        n;
        logic        taken;
        logic [7:0]  mark;
        emit(mvi_word(REG_X, 1'b1, x[15:8]));
        emit(mvi_word(REG_X, 1'b0, x[7:0]));
        emit(adi_word(REG_X, imm));
        emit(mvi_word(REG_W, 1'b0, MARK_TAKEN + 8'(idx)));
        emit(branch_word(cond, 10'd2));
        emit(mvi_word(REG_W, 1'b0, MARK_NOT_TAKEN + 8'(idx)));
        emit(mem_word(OP_STORE, REG_A, REG_W, 8'(idx)));
        sum   = {1'b0, x} + {1'b0, sign_extend10(imm)};
        c     = sum[16];
        z     = (sum[15:0] == 16'h0000);
        n     = sum[15];
        taken = ((cond[2] & c) | (cond[1] & z) | (cond[0] & n)) ^ cond[3];
        mark  = taken ? MARK_TAKEN + 8'(idx) : MARK_NOT_TAKEN + 8'(idx);
        expect_store(16'h0080 + 16'(idx), {8'h00, mark});
    endtask

    task automatic build_add_branch();
        logic [9:0] imm;
        emit(mvi_word(REG_A, 1'b1, 8'h00));
        emit(mvi_word(REG_A, 1'b0, 8'h80));
        emit(mvi_word(REG_W, 1'b1, 8'h00));
        // carry, branch if no carry
        add_case(0, {8'hff, rand_byte()}, {2'b01, rand_byte()}, 4'hc);
        // zero result, branch if not zero
        imm = {2'(rand_byte()), rand_byte()};
        add_case(1, 16'h0000 - sign_extend10(imm), imm, 4'ha);
        // negative result, branch if n
        add_case(2, {9'h000, 7'(rand_byte())}, {3'b100, 7'(rand_byte())}, 4'h1);
        // positive result, inverted test on all flags
        add_case(3, {8'h00, rand_byte() | 8'h01}, {2'b00, rand_byte()}, 4'hf);
        emit(WORD_HALT);
    endtask

    task automatic build_load_store();
        word_t      val;
        logic [7:0] off;
        val = {rand_byte(), rand_byte()};
        off = 8'h01 + (rand_byte() & 8'h3e);
        emit(mvi_word(REG_X, 1'b1, val[15:8]));
        emit(mvi_word(REG_X, 1'b0, val[7:0]));
        emit(mvi_word(REG_A, 1'b1, 8'h00));
        emit(mvi_word(REG_A, 1'b0, 8'hc0));
        emit(mem_word(OP_STORE, REG_A, REG_X, 8'h00));
        emit(mem_word(OP_LOAD, REG_W, REG_A, 8'h00));
        emit(WORD_NOP);
        emit(mem_word(OP_STORE, REG_A, REG_W, off));
        emit(WORD_HALT);
        expect_store(16'h00c0, val);
        expect_store(16'h00c0 + {8'h00, off}, val);
    endtask

    task automatic build_illegal();
        word_t val;
        val = {rand_byte(), rand_byte()};
        emit(mvi_word(REG_X, 1'b1, val[15:8]));
        emit(mvi_word(REG_X, 1'b0, val[7:0]));
        emit(mvi_word(REG_A, 1'b1, 8'h00));
        emit(mvi_word(REG_A, 1'b0, 8'h90));
        emit(mem_word(OP_STORE, REG_A, REG_X, 8'h00));
        // opcode nibble 2 is unused
        emit(16'h0020);
        emit(mem_word(OP_STORE, REG_A, REG_X, 8'h01));
        emit(WORD_HALT);
        expect_store(16'h0090, val);
    endtask

    // reset, load under reset, release and wait for hlt
    task automatic run_program(input string name, input logic expect_err);
        int limit;
        int cycles;
        test_name = name;
        @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clk);
        foreach (prog[i]) begin
            #2;
            prog_we   = 1'b1;
            prog_addr = ADDR_BITS'(i);
            prog_data = prog[i];
            @(posedge clk);
        end
        #2;
        prog_we = 1'b0;
        reset   = 1'b1;
        limit  = prog.size() * (4 + 2 * WAIT_CYCLES) + 20;
        cycles = 0;
        while (hlt !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (hlt !== 1'b1) begin
            timeouts++;
            $display("timeout: %s did not halt within %0d cycles", name, limit);
        end else begin
            assert (error === expect_err)
            else begin
                check_errors++;
                $display("ERROR %s error flag expected %b actual %b", name, expect_err, error);
            end
        end
        // room for a stray store after halt
        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            check_errors++;
            $display("%s ended with %0d expected stores never seen", name, exp_q.size());
        end
        exp_q.delete();
        prog.delete();
    endtask

    // one compare per write strobe
    always @(negedge clk) begin
        if (reset && bus_wr && !wr_seen) begin
            if (exp_q.size() == 0) begin
                check_errors++;
                $display("%s wrote %h to %h when no store was due",
                         test_name, bus_wdata, bus_address);
            end else begin
                exp_word = exp_q.pop_front();
                assert (bus_address === exp_word[31:16] && bus_wdata === exp_word[15:0])
                else begin
                    store_errors++;
                    $display("ERROR %s expected %h at %h actual %h at %h", test_name,
                             exp_word[15:0], exp_word[31:16], bus_wdata, bus_address);
                end
            end
        end
        wr_seen = bus_wr;
    end

    task automatic finish_run();
        int total;
        total = store_errors + check_errors + timeouts + tiny16_system_inst.u_assert.fail_count;
        $display("errors: store %0d, check %0d, timeout %0d, assertion %0d",
                 store_errors, check_errors, timeouts, tiny16_system_inst.u_assert.fail_count);
        if (total == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        timeouts++;
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_run();
    end

    initial begin
        reset     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_move_store();
        run_program("imm_move_store", 1'b0);
        build_add_branch();
        run_program("add_flags_branch", 1'b0);
        build_load_store();
        run_program("load_store", 1'b0);
        build_illegal();
        run_program("illegal_word", 1'b1);
        finish_run();
    end

endmodule

`default_nettype wire

// File: tiny16_system.f
design/tiny16_isa_pkg.sv
design/tiny16_sys_pkg.sv
design/tiny16_decoder.sv
design/tiny16_core.sv
design/tiny16_memory.sv
design/tiny16_system.sv
dv/tiny16_system_assert.sv
dv/tiny16_system_tb.sv
